// ==== project.f ====
+incdir+rtl
rtl/pinmux_pkg.sv
rtl/pinmux_timebase.sv
rtl/pwm_gen.sv
rtl/pad_mux.sv
rtl/pinmux_top.sv
sim/pinmux_asserts.sv
sim/tb_pinmux.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pin mux testbench with Verilator
set -e -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_pinmux

./obj_dir/Vtb_pinmux | tee sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// ==== sim/tb_pinmux.sv ====
//////////////////////////////
// Pin mux testbench
// Timebase, PWM and pad routing checks
//////////////////////////////

`timescale 1ns/1ps

`include "pinmux_config.svh"

module tb_pinmux;

  localparam int TIMEOUT_CYC = 200000;
  localparam pinmux_pkg::us_div_t US_DIV = pinmux_pkg::us_div_t'(1);

  // Expected pad mux outputs
  typedef struct packed {
    pinmux_pkg::pad_vec_t out;
    pinmux_pkg::pad_vec_t oen;
    pinmux_pkg::pad_vec_t gin;
    logic                 rxd;
  } pad_exp_t;

  logic                 mclk_i;
  logic                 rst_n_i;
  pinmux_pkg::us_div_t  us_div_i;
  pinmux_pkg::pwm_cfg_t pwm0_cfg_i;
  pinmux_pkg::pwm_cfg_t pwm1_cfg_i;
  pinmux_pkg::pad_cfg_t pad_cfg_i;
  pinmux_pkg::pad_vec_t pad_in_i;
  logic                 uart_txd_i;
  logic                 pulse1m_o;
  pinmux_pkg::pwm_vec_t pwm_wfm_o;
  pinmux_pkg::pad_vec_t pad_out_o;
  pinmux_pkg::pad_vec_t pad_oen_o;
  pinmux_pkg::pad_vec_t gpio_in_o;
  logic                 uart_rxd_o;

  int err_cnt   = 0;
  int chk_cnt   = 0;
  int test_err  = 0;
  int cycle_cnt = 0;

  pinmux_top i_pinmux_top (
    .mclk_i     (mclk_i),
    .rst_n_i    (rst_n_i),
    .us_div_i   (us_div_i),
    .pwm0_cfg_i (pwm0_cfg_i),
    .pwm1_cfg_i (pwm1_cfg_i),
    .pad_cfg_i  (pad_cfg_i),
    .pad_in_i   (pad_in_i),
    .uart_txd_i (uart_txd_i),
    .pulse1m_o  (pulse1m_o),
    .pwm_wfm_o  (pwm_wfm_o),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .gpio_in_o  (gpio_in_o),
    .uart_rxd_o (uart_rxd_o)
  );

  // 100 ns clock
  always #50 mclk_i = ~mclk_i;

  // Run limit of about four times the PWM tests
  always @(posedge mclk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: simulation ran %0d cycles without finishing", cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Reference and compare
  //////////////////////////////
  // Peripheral claims before GPIO direction
  function automatic pad_exp_t ref_pad(pinmux_pkg::pad_cfg_t cfg, pinmux_pkg::pwm_vec_t wfm,
                                       logic txd, pinmux_pkg::pad_vec_t pin);
    pad_exp_t e;
    for (int p = 0; p < `PINMUX_PAD_CNT; p++) begin
      if (cfg.uart_en && p == `PINMUX_PAD_UART_RXD) begin
        e.out[p] = 1'b0;
        e.oen[p] = 1'b1;
      end else if (cfg.uart_en && p == `PINMUX_PAD_UART_TXD) begin
        e.out[p] = txd;
        e.oen[p] = 1'b0;
      end else if (cfg.pwm_en[0] && p == `PINMUX_PAD_PWM0) begin
        e.out[p] = wfm[0];
        e.oen[p] = 1'b0;
      end else if (cfg.pwm_en[1] && p == `PINMUX_PAD_PWM1) begin
        e.out[p] = wfm[1];
        e.oen[p] = 1'b0;
      end else begin
        // Plain GPIO with input pads driving 0
        e.out[p] = cfg.gpio_dir[p] & cfg.gpio_out[p];
        e.oen[p] = ~cfg.gpio_dir[p];
      end
    end
    e.gin = pin;
    e.rxd = cfg.uart_en ? pin[`PINMUX_PAD_UART_RXD] : 1'b0;
    return e;
  endfunction

  task automatic check_pad(string name, pinmux_pkg::pad_vec_t exp, pinmux_pkg::pad_vec_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(string name, pinmux_pkg::pwm_dur_t exp, pinmux_pkg::pwm_dur_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // Pad mux compared on every falling edge after reset
  always @(negedge mclk_i) begin
    pad_exp_t e;
    if (rst_n_i) begin
      e = ref_pad(pad_cfg_i, pwm_wfm_o, uart_txd_i, pad_in_i);
      check_pad("pad_out_o", e.out, pad_out_o);
      check_pad("pad_oen_o", e.oen, pad_oen_o);
      check_pad("gpio_in_o", e.gin, gpio_in_o);
      check_bit("uart_rxd_o", e.rxd, uart_rxd_o);
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  task automatic report_test(string name);
    $display("%s: %0d errors", name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  // Random GPIO setup and pad inputs
  task automatic drive_random(logic uart_en, pinmux_pkg::pwm_vec_t pwm_en);
    pinmux_pkg::pad_cfg_t c;
    c.gpio_dir = pinmux_pkg::pad_vec_t'($urandom);
    c.gpio_out = pinmux_pkg::pad_vec_t'($urandom);
    c.uart_en  = uart_en;
    c.pwm_en   = pwm_en;
    @(posedge mclk_i);
    pad_cfg_i  <= c;
    pad_in_i   <= pinmux_pkg::pad_vec_t'($urandom);
    uart_txd_i <= 1'($urandom);
    @(negedge mclk_i);
  endtask

  // Update only the GPIO direction bits
  task automatic set_gpio_dir(pinmux_pkg::pad_vec_t dir);
    @(posedge mclk_i);
    pad_cfg_i.gpio_dir <= dir;
    @(negedge mclk_i);
  endtask

  task automatic set_pwm(int ch, pinmux_pkg::pwm_cfg_t cfg);
    @(posedge mclk_i);
    if (ch == 0) begin
      pwm0_cfg_i <= cfg;
    end else begin
      pwm1_cfg_i <= cfg;
    end
    @(negedge mclk_i);
  endtask

  // Cycles up to the next ms pulse
  task automatic next_pulse(output int n);
    n = 0;
    do begin
      @(negedge mclk_i);
      n++;
    end while (pulse1m_o !== 1'b1);
  endtask

  task automatic wait_level(int ch, logic lvl);
    while (pwm_wfm_o[ch] !== lvl) @(negedge mclk_i);
  endtask

  // ms pulses seen while the waveform keeps its level
  task automatic measure_phase(int ch, output int n);
    logic lvl;
    lvl = pwm_wfm_o[ch];
    n = 0;
    while (pwm_wfm_o[ch] === lvl) begin
      if (pulse1m_o) n++;
      @(negedge mclk_i);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int n;
    pinmux_pkg::pwm_cfg_t cfg;
    pinmux_pkg::pad_vec_t pad_bit;
    void'($urandom(32'h19ed_5932));
    mclk_i     = 1'b0;
    rst_n_i    = 1'b0;
    us_div_i   = US_DIV;
    pwm0_cfg_i = '0;
    pwm1_cfg_i = '0;
    pad_cfg_i  = '0;
    pad_in_i   = '0;
    uart_txd_i = 1'b0;
    repeat (3) @(posedge mclk_i);
    rst_n_i <= 1'b1;
    @(negedge mclk_i);

    // Idle outputs after reset
    check_bit("pulse1m_o", 1'b0, pulse1m_o);
    check_bit("pwm_wfm_o[0]", 1'b0, pwm_wfm_o[0]);
    check_bit("pwm_wfm_o[1]", 1'b0, pwm_wfm_o[1]);
    check_pad("pad_oen_o", '1, pad_oen_o);
    report_test("reset state");

    next_pulse(n);
    repeat (3) begin
      next_pulse(n);
      check_count("pulse1m interval",
                  pinmux_pkg::pwm_dur_t'(`PINMUX_US_PER_MS * (int'(US_DIV) + 1)),
                  pinmux_pkg::pwm_dur_t'(n));
    end
    report_test("ms pulse spacing");

    repeat (50) drive_random(1'b0, '0);
    report_test("gpio routing");

    repeat (20) drive_random(1'b1, '0);
    repeat (10) drive_random(1'b0, '0);
    report_test("uart routing");

    // Skip the first period and time one high and one low phase
    for (int ch = 0; ch < `PINMUX_PWM_CNT; ch++) begin
      cfg.enable = 1'b1;
      cfg.high   = pinmux_pkg::pwm_dur_t'($urandom_range(4, 1));
      cfg.low    = pinmux_pkg::pwm_dur_t'($urandom_range(4, 1));
      pad_bit    = pinmux_pkg::pad_vec_t'(1) <<
                   ((ch == 0) ? `PINMUX_PAD_PWM0 : `PINMUX_PAD_PWM1);
      drive_random(1'b0, pinmux_pkg::pwm_vec_t'(1 << ch));
      // PWM pad set as GPIO input for the first period
      set_gpio_dir(pad_cfg_i.gpio_dir & ~pad_bit);
      set_pwm(ch, cfg);
      wait_level(ch, 1'b1);
      wait_level(ch, 1'b0);
      // GPIO output on the PWM pad while timing
      set_gpio_dir(pad_cfg_i.gpio_dir | pad_bit);
      wait_level(ch, 1'b1);
      measure_phase(ch, n);
      check_count("pwm high phase", cfg.high, pinmux_pkg::pwm_dur_t'(n));
      measure_phase(ch, n);
      check_count("pwm low phase", cfg.low, pinmux_pkg::pwm_dur_t'(n));
    end
    report_test("pwm waveform");

    // Disable in the middle of a high phase
    for (int ch = 0; ch < `PINMUX_PWM_CNT; ch++) begin
      wait_level(ch, 1'b1);
      set_pwm(ch, '0);
      @(negedge mclk_i);
      check_bit("pwm_wfm_o", 1'b0, pwm_wfm_o[ch]);
      repeat (5) drive_random(1'b0, '0);
    end
    report_test("pwm disable");

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/pinmux_asserts.sv ====
//////////////////////////////
// Pin mux assertions
// Pulse width and PWM disable checks
//////////////////////////////

`timescale 1ns/1ps

module pinmux_asserts (
  input logic                   mclk_i,
  input logic                   rst_n_i,
  input logic                   pulse_i,
  input logic                   en_i,
  input logic                   wfm_i,
  input pinmux_pkg::pwm_state_e state_i
);

  // ms strobe is one cycle wide
  a_pulse_single: assert property (
    @(posedge mclk_i) disable iff (!rst_n_i) pulse_i |=> !pulse_i
  ) else $error("pulse1m held high for two cycles");

  // State is registered, so the waveform drops one cycle after enable
  a_wfm_off: assert property (
    @(posedge mclk_i) disable iff (!rst_n_i) !en_i |=> !wfm_i
  ) else $error("PWM waveform high while disabled");

  a_no_low_off: assert property (
    @(posedge mclk_i) disable iff (!rst_n_i) !en_i |=> (state_i != pinmux_pkg::LOW)
  ) else $error("PWM state LOW while disabled");

endmodule

// Timebase only has the pulse, PWM checks stay vacuous there
bind pinmux_timebase pinmux_asserts i_timebase_asserts (
  .mclk_i  (mclk_i),
  .rst_n_i (rst_n_i),
  .pulse_i (pulse1m_o),
  .en_i    (1'b1),
  .wfm_i   (1'b0),
  .state_i (pinmux_pkg::IDLE)
);

bind pwm_gen pinmux_asserts i_pwm_asserts (
  .mclk_i  (mclk_i),
  .rst_n_i (rst_n_i),
  .pulse_i (pulse1m_i),
  .en_i    (cfg_i.enable),
  .wfm_i   (wfm_o),
  .state_i (state_q)
);

// ==== rtl/pinmux_top.sv ====
//////////////////////////////
// Pin mux top
// Timebase, two PWM channels, pad mux
//////////////////////////////

`timescale 1ns/1ps

module pinmux_top (
  input  logic                 mclk_i,
  input  logic                 rst_n_i,
  input  pinmux_pkg::us_div_t  us_div_i,
  input  pinmux_pkg::pwm_cfg_t pwm0_cfg_i,
  input  pinmux_pkg::pwm_cfg_t pwm1_cfg_i,
  input  pinmux_pkg::pad_cfg_t pad_cfg_i,
  input  pinmux_pkg::pad_vec_t pad_in_i,
  input  logic                 uart_txd_i,
  output logic                 pulse1m_o,
  output pinmux_pkg::pwm_vec_t pwm_wfm_o,
  output pinmux_pkg::pad_vec_t pad_out_o,
  output pinmux_pkg::pad_vec_t pad_oen_o,
  output pinmux_pkg::pad_vec_t gpio_in_o,
  output logic                 uart_rxd_o
);

  // ms strobe shared by both channels
  logic                 pulse1m;
  pinmux_pkg::pwm_vec_t pwm_wfm;

  pinmux_timebase u_timebase (
    .mclk_i    (mclk_i),
    .rst_n_i   (rst_n_i),
    .us_div_i  (us_div_i),
    .pulse1m_o (pulse1m)
  );

  // PWM channel 0, pad 3
  pwm_gen u_pwm0 (
    .mclk_i    (mclk_i),
    .rst_n_i   (rst_n_i),
    .pulse1m_i (pulse1m),
    .cfg_i     (pwm0_cfg_i),
    .wfm_o     (pwm_wfm[0])
  );

  // PWM channel 1, pad 4
  pwm_gen u_pwm1 (
    .mclk_i    (mclk_i),
    .rst_n_i   (rst_n_i),
    .pulse1m_i (pulse1m),
    .cfg_i     (pwm1_cfg_i),
    .wfm_o     (pwm_wfm[1])
  );

  pad_mux u_pad_mux (
    .cfg_i      (pad_cfg_i),
    .pwm_wfm_i  (pwm_wfm),
    .uart_txd_i (uart_txd_i),
    .pad_in_i   (pad_in_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .gpio_in_o  (gpio_in_o),
    .uart_rxd_o (uart_rxd_o)
  );

  assign pulse1m_o = pulse1m;
  assign pwm_wfm_o = pwm_wfm;

endmodule

// ==== rtl/pad_mux.sv ====
//////////////////////////////
// Pad multiplexer
// Out, oen and input routing per pad
//////////////////////////////

`timescale 1ns/1ps

`include "pinmux_config.svh"

module pad_mux (
  input  pinmux_pkg::pad_cfg_t cfg_i,
  input  pinmux_pkg::pwm_vec_t pwm_wfm_i,
  input  logic                 uart_txd_i,
  input  pinmux_pkg::pad_vec_t pad_in_i,
  output pinmux_pkg::pad_vec_t pad_out_o,
  output pinmux_pkg::pad_vec_t pad_oen_o,
  output pinmux_pkg::pad_vec_t gpio_in_o,
  output logic                 uart_rxd_o
);

  //////////////////////////////
  // Output and enable select
  //////////////////////////////
  // oen is active low
  // GPIO first, peripherals override
  always_comb begin
    for (int i = 0; i < `PINMUX_PAD_CNT; i++) begin
      if (cfg_i.gpio_dir[i]) begin
        pad_out_o[i] = cfg_i.gpio_out[i];
        pad_oen_o[i] = 1'b0;
      end else begin
        pad_out_o[i] = 1'b0;
        pad_oen_o[i] = 1'b1;
      end
    end

    // UART pair
    if (cfg_i.uart_en) begin
      // RXD is a pure input
      pad_out_o[`PINMUX_PAD_UART_RXD] = 1'b0;
      pad_oen_o[`PINMUX_PAD_UART_RXD] = 1'b1;
      pad_out_o[`PINMUX_PAD_UART_TXD] = uart_txd_i;
      pad_oen_o[`PINMUX_PAD_UART_TXD] = 1'b0;
    end

    // PWM outputs, same priority on both pads
    if (cfg_i.pwm_en[0]) begin
      pad_out_o[`PINMUX_PAD_PWM0] = pwm_wfm_i[0];
      pad_oen_o[`PINMUX_PAD_PWM0] = 1'b0;
    end
    if (cfg_i.pwm_en[1]) begin
      pad_out_o[`PINMUX_PAD_PWM1] = pwm_wfm_i[1];
      pad_oen_o[`PINMUX_PAD_PWM1] = 1'b0;
    end
  end

  //////////////////////////////
  // Input side
  //////////////////////////////
  // GPIO sees every pad
  assign gpio_in_o  = pad_in_i;

  // Receive data only while UART owns the pad
  assign uart_rxd_o = cfg_i.uart_en & pad_in_i[`PINMUX_PAD_UART_RXD];

endmodule

// ==== rtl/pwm_gen.sv ====
//////////////////////////////
// PWM channel
// High/low FSM stepped by ms pulses
//////////////////////////////

`timescale 1ns/1ps

module pwm_gen (
  input  logic                 mclk_i,
  input  logic                 rst_n_i,
  input  logic                 pulse1m_i,
  input  pinmux_pkg::pwm_cfg_t cfg_i,
  output logic                 wfm_o
);

  pinmux_pkg::pwm_state_e state_q;
  pinmux_pkg::pwm_dur_t   cnt_q;
  pinmux_pkg::pwm_dur_t   high_last;
  pinmux_pkg::pwm_dur_t   low_last;

  // Terminal counts, durations are at least 1
  assign high_last = cfg_i.high - 1'b1;
  assign low_last  = cfg_i.low - 1'b1;

  //////////////////////////////
  // Phase FSM
  //////////////////////////////
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= pinmux_pkg::IDLE;
      cnt_q   <= '0;
    end else if (!cfg_i.enable) begin
      // Disable wins from any state
      state_q <= pinmux_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        pinmux_pkg::IDLE: begin
          // Start with a high phase
          state_q <= pinmux_pkg::HIGH;
          cnt_q   <= '0;
        end
        pinmux_pkg::HIGH: begin
          if (pulse1m_i) begin
            if (cnt_q == high_last) begin
              state_q <= pinmux_pkg::LOW;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        pinmux_pkg::LOW: begin
          if (pulse1m_i) begin
            if (cnt_q == low_last) begin
              state_q <= pinmux_pkg::HIGH;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        default: begin
          // Unused encoding, recover to idle
          state_q <= pinmux_pkg::IDLE;
          cnt_q   <= '0;
        end
      endcase
    end
  end

  // Waveform straight from state, no extra delay
  assign wfm_o = (state_q == pinmux_pkg::HIGH);

endmodule

// ==== rtl/pinmux_timebase.sv ====
//////////////////////////////
// Pin mux timebase
// Programmable us strobe and the
// derived one-cycle ms pulse
//////////////////////////////

`timescale 1ns/1ps

`include "pinmux_config.svh"

module pinmux_timebase (
  input  logic                mclk_i,
  input  logic                rst_n_i,
  input  pinmux_pkg::us_div_t us_div_i,
  output logic                pulse1m_o
);

  // Last strobe count before the ms pulse
  localparam pinmux_pkg::ms_cnt_t MS_LAST = pinmux_pkg::ms_cnt_t'(`PINMUX_US_PER_MS - 1);

  pinmux_pkg::us_div_t us_cnt_q;
  logic                pulse1u_q;
  pinmux_pkg::ms_cnt_t ms_cnt_q;
  logic                pulse1m_q;

  //////////////////////////////
  // Microsecond strobe
  //////////////////////////////
  // Period is us_div_i + 1 cycles
  // Compare with >= so a smaller reload takes effect at once
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      us_cnt_q  <= '0;
      pulse1u_q <= 1'b0;
    end else if (us_cnt_q >= us_div_i) begin
      us_cnt_q  <= '0;
      pulse1u_q <= 1'b1;
    end else begin
      us_cnt_q  <= us_cnt_q + 1'b1;
      pulse1u_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Millisecond pulse
  //////////////////////////////
  // Counts strobes, pulse follows the 1000th one
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ms_cnt_q  <= '0;
      pulse1m_q <= 1'b0;
    end else begin
      pulse1m_q <= 1'b0;
      if (pulse1u_q) begin
        if (ms_cnt_q == MS_LAST) begin
          ms_cnt_q  <= '0;
          pulse1m_q <= 1'b1;
        end else begin
          ms_cnt_q  <= ms_cnt_q + 1'b1;
        end
      end
    end
  end

  assign pulse1m_o = pulse1m_q;

endmodule

// ==== rtl/pinmux_pkg.sv ====
//////////////////////////////
// Pin mux types
// Vector widths, config structs, PWM states
//////////////////////////////

`include "pinmux_config.svh"

package pinmux_pkg;

  // One bit per pad
  typedef logic [`PINMUX_PAD_CNT-1:0]   pad_vec_t;
  // PWM phase length in ms
  typedef logic [`PINMUX_PWM_DUR_W-1:0] pwm_dur_t;
  // Microsecond divider reload
  typedef logic [`PINMUX_US_DIV_W-1:0]  us_div_t;
  // Microsecond strobes seen within a ms
  typedef logic [`PINMUX_MS_CNT_W-1:0]  ms_cnt_t;
  // One bit per PWM channel
  typedef logic [`PINMUX_PWM_CNT-1:0]   pwm_vec_t;

  // PWM channel FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    HIGH = 2'd1,
    LOW  = 2'd2
  } pwm_state_e;

  // Per-channel PWM setup
  typedef struct packed {
    logic     enable;
    pwm_dur_t high;
    pwm_dur_t low;
  } pwm_cfg_t;

  // Pad setup, dir bit 1 means output
  typedef struct packed {
    pad_vec_t gpio_dir;
    pad_vec_t gpio_out;
    logic     uart_en;
    pwm_vec_t pwm_en;
  } pad_cfg_t;

endpackage

// ==== rtl/pinmux_config.svh ====
//////////////////////////////
// Pin mux configuration
// Pad count, channel count, field widths
// and fixed pad positions
//////////////////////////////

`ifndef PINMUX_CONFIG_SVH
`define PINMUX_CONFIG_SVH

// Sizes
`define PINMUX_PAD_CNT       8
`define PINMUX_PWM_CNT       2

// Field widths
`define PINMUX_PWM_DUR_W     16
`define PINMUX_US_DIV_W      10
`define PINMUX_MS_CNT_W      10

// Microsecond strobes per millisecond
`define PINMUX_US_PER_MS     1000

// Pad positions of the peripheral pins
`define PINMUX_PAD_UART_RXD  0
`define PINMUX_PAD_UART_TXD  1
`define PINMUX_PAD_PWM0      3
`define PINMUX_PAD_PWM1      4

`endif
